// File: compile.f
source/alu_pkg.sv
source/core_pkg.sv
source/sync_fifo.sv
source/operand_issue.sv
source/alu_execute.sv
source/alu_core_top.sv
verification/alu_core_props.sv
verification/alu_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, the exit status carries the verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module alu_core_tb \
    -f compile.f \
    -o alu_core_sim \
    && ./obj_dir/alu_core_sim \
    || { echo "simulation did not pass"; exit 1; }

exit 0

// File: source/alu_core_top.sv
`timescale 1ns/100ps

module alu_core_top
(
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            instr_valid,
    input  alu_pkg::opcode_t                instr_op,
    input  core_pkg::reg_addr_t             instr_rd,
    input  core_pkg::reg_addr_t             instr_rs1,
    input  core_pkg::reg_addr_t             instr_rs2,
    input  logic [alu_pkg::imm_width-1:0]   instr_imm,
    input  logic                            instr_high,
    output logic                            instr_ready,
    input  logic                            res_pop,
    output logic                            res_valid,
    output core_pkg::result_t               res_data
);

    logic                   op_push;
    logic                   op_pop;
    logic                   op_empty;
    logic                   op_full;
    core_pkg::op_entry_t    op_entry;
    core_pkg::op_entry_t    op_head;
    logic                   res_push;
    logic                   res_empty;
    logic                   res_full;
    core_pkg::result_t      res_entry;
    logic                   wb_en;
    core_pkg::reg_addr_t    wb_addr;
    alu_pkg::data_t         wb_data;

    assign res_valid = ~res_empty;

    // ******************************
    // Issue and operation queue
    // ******************************
    operand_issue u_issue
    (
        .clock       (clock),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr_op    (instr_op),
        .instr_rd    (instr_rd),
        .instr_rs1   (instr_rs1),
        .instr_rs2   (instr_rs2),
        .instr_imm   (instr_imm),
        .instr_high  (instr_high),
        .instr_ready (instr_ready),
        .op_full     (op_full),
        .op_push     (op_push),
        .op_entry    (op_entry),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data)
    );

    sync_fifo #(.payload_t(core_pkg::op_entry_t), .depth(core_pkg::op_depth)) u_op_queue
    (
        .clock     (clock),
        .arst_n    (arst_n),
        .push      (op_push),
        .push_data (op_entry),
        .pop       (op_pop),
        .head      (op_head),
        .empty     (op_empty),
        .full      (op_full)
    );

    // ******************************
    // Execute and result queue
    // ******************************
    alu_execute u_execute
    (
        .clock     (clock),
        .arst_n    (arst_n),
        .op_empty  (op_empty),
        .op_head   (op_head),
        .op_pop    (op_pop),
        .res_full  (res_full),
        .res_push  (res_push),
        .res_entry (res_entry),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    sync_fifo #(.payload_t(core_pkg::result_t), .depth(core_pkg::res_depth)) u_res_queue
    (
        .clock     (clock),
        .arst_n    (arst_n),
        .push      (res_push),
        .push_data (res_entry),
        .pop       (res_pop),
        .head      (res_data),
        .empty     (res_empty),
        .full      (res_full)
    );

endmodule

// File: source/alu_execute.sv
`timescale 1ns/100ps

module alu_execute
(
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    op_empty,
    input  core_pkg::op_entry_t     op_head,
    output logic                    op_pop,
    input  logic                    res_full,
    output logic                    res_push,
    output core_pkg::result_t       res_entry,
    output logic                    wb_en,
    output core_pkg::reg_addr_t     wb_addr,
    output alu_pkg::data_t          wb_data
);

    alu_pkg::data_t     a;
    alu_pkg::data_t     b;
    alu_pkg::data_t     shl_val;
    alu_pkg::data_t     shr_val;
    alu_pkg::data_t     ldh_val;
    alu_pkg::data_t     mul_val;
    alu_pkg::data_t     div_val;
    alu_pkg::data_t     alu_val;
    alu_pkg::data_t     target;
    logic               wide_shift;
    logic               flag;
    logic               flag_next;
    logic               taken;

    assign a = op_head.a;
    assign b = op_head.b;

    // A result in flight is not yet seen by res_full
    assign op_pop = ~op_empty & ~res_full & ~res_push;

    // ******************************
    // Function units
    // ******************************
    assign wide_shift = |b[alu_pkg::data_width-1:6];

    // Shift the inverse so the vacated bits come back as ones
    assign shl_val = wide_shift ? '1 : ~((~a) << b[5:0]);
    assign shr_val = wide_shift ? '1 : ~((~a) >> b[5:0]);

    assign ldh_val = op_head.high ? {op_head.imm, a[alu_pkg::imm_width-1:0]}
                                  : {a[alu_pkg::data_width-1:alu_pkg::imm_width], op_head.imm};

    assign mul_val = a * b;  // Low half of the product
    assign div_val = (b == '0) ? '1 : a / b;

    // ******************************
    // Result select
    // ******************************
    always_comb
    begin
        alu_val   = '0;
        flag_next = flag;
        taken     = 1'b0;
        target    = '0;
        case (op_head.op)
            alu_pkg::op_add: alu_val = a + b;
            alu_pkg::op_sub: alu_val = a - b;
            alu_pkg::op_shl: alu_val = shl_val;
            alu_pkg::op_shr: alu_val = shr_val;
            alu_pkg::op_mov: alu_val = a;
            alu_pkg::op_ldh: alu_val = ldh_val;
            alu_pkg::op_ceq: flag_next = (a == b);
            alu_pkg::op_clt: flag_next = (a < b);
            alu_pkg::op_cgt: flag_next = (a > b);
            alu_pkg::op_mul: alu_val = mul_val;
            alu_pkg::op_div: alu_val = div_val;
            alu_pkg::op_br:
            begin
                alu_val = a;
                taken   = 1'b1;
                target  = op_head.link;
            end
            alu_pkg::op_brf:
            begin
                alu_val = a;
                taken   = flag;  // Flag from the last compare
                target  = op_head.link;
            end
            default: alu_val = '0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            flag     <= 1'b0;
            res_push <= 1'b0;
            wb_en    <= 1'b0;
        end
        else
        begin
            res_push <= op_pop;
            wb_en    <= op_pop & alu_pkg::writes_reg(op_head.op);
            if (op_pop)
            begin
                flag <= flag_next;
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (op_pop)
        begin
            res_entry.op     <= op_head.op;
            res_entry.dest   <= op_head.dest;
            res_entry.value  <= alu_val;
            res_entry.flag   <= flag_next;
            res_entry.taken  <= taken;
            res_entry.target <= target;
            wb_addr          <= op_head.dest;
            wb_data          <= alu_val;
        end
    end

endmodule

// File: source/alu_pkg.sv
package alu_pkg;

    // ******************************
    // Datapath widths
    // ******************************
    localparam int data_width = 64;
    localparam int imm_width  = 32;

    typedef logic [data_width-1:0] data_t;

    // ******************************
    // Opcodes
    // ******************************
    typedef enum logic [4:0]
    {
        op_add = 5'd0,
        op_sub = 5'd1,
        op_shl = 5'd2,  // Ones fill from the right
        op_shr = 5'd3,  // Ones fill from the left
        op_mov = 5'd4,
        op_ldh = 5'd5,  // Immediate into one half of a
        op_br  = 5'd6,
        op_brf = 5'd7,  // Taken only when the flag is set
        op_ceq = 5'd8,
        op_clt = 5'd9,
        op_cgt = 5'd10,
        op_mul = 5'd16,
        op_div = 5'd17
    } opcode_t;

    // Compares and branches leave the register file alone
    function automatic logic writes_reg(input opcode_t op);
        case (op)
            op_add, op_sub, op_shl, op_shr, op_mov, op_ldh, op_mul, op_div:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    function automatic logic is_branch(input opcode_t op);
        return (op == op_br) || (op == op_brf);
    endfunction

endpackage

// File: source/core_pkg.sv
package core_pkg;

    // ******************************
    // Register file and queues
    // ******************************
    localparam int reg_count = 16;

    typedef logic [$clog2(reg_count)-1:0] reg_addr_t;

    localparam reg_addr_t link_reg = reg_addr_t'(8);  // Branch target source

    localparam int op_depth  = 4;
    localparam int res_depth = 4;

    // ******************************
    // Queue payloads
    // ******************************
    typedef struct packed
    {
        alu_pkg::opcode_t                 op;
        reg_addr_t                        dest;
        alu_pkg::data_t                   a;
        alu_pkg::data_t                   b;
        alu_pkg::data_t                   link;  // Value of the link register at issue
        logic [alu_pkg::imm_width-1:0]    imm;
        logic                             high;
    } op_entry_t;

    typedef struct packed
    {
        alu_pkg::opcode_t   op;
        reg_addr_t          dest;
        alu_pkg::data_t     value;
        logic               flag;    // Flag after the operation
        logic               taken;
        alu_pkg::data_t     target;  // Zero unless a branch
    } result_t;

endpackage

// File: source/operand_issue.sv
`timescale 1ns/100ps

module operand_issue
(
    input  logic                            clock,
    input  logic                            arst_n,
    input  logic                            instr_valid,
    input  alu_pkg::opcode_t                instr_op,
    input  core_pkg::reg_addr_t             instr_rd,
    input  core_pkg::reg_addr_t             instr_rs1,
    input  core_pkg::reg_addr_t             instr_rs2,
    input  logic [alu_pkg::imm_width-1:0]   instr_imm,
    input  logic                            instr_high,
    output logic                            instr_ready,
    input  logic                            op_full,
    output logic                            op_push,
    output core_pkg::op_entry_t             op_entry,
    input  logic                            wb_en,
    input  core_pkg::reg_addr_t             wb_addr,
    input  alu_pkg::data_t                  wb_data
);

    alu_pkg::data_t                     regs [core_pkg::reg_count];
    logic [core_pkg::reg_count-1:0]     pending;  // One bit per register awaiting writeback
    logic                               run;
    logic                               link_busy;
    logic                               hazard;
    logic                               accept;

    // ******************************
    // Scoreboard and acceptance
    // ******************************
    assign link_busy = alu_pkg::is_branch(instr_op) & pending[core_pkg::link_reg];

    assign hazard = pending[instr_rs1] | pending[instr_rs2] | pending[instr_rd] | link_busy;

    // A push in flight is not yet counted by op_full, so wait for it to land
    assign instr_ready = run & ~op_full & ~op_push & ~hazard;

    assign accept = instr_valid & instr_ready;

    // ******************************
    // Register file and control
    // ******************************
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            run     <= 1'b0;
            op_push <= 1'b0;
            pending <= '0;
            for (int i = 0; i < core_pkg::reg_count; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            run     <= 1'b1;  // Opens the input one cycle after reset ends
            op_push <= accept;
            if (wb_en)
            begin
                regs[wb_addr]    <= wb_data;
                pending[wb_addr] <= 1'b0;
            end
            if (accept && alu_pkg::writes_reg(instr_op))
            begin
                pending[instr_rd] <= 1'b1;  // Never the register being written back
            end
        end
    end

    // Operands are read on the accepting edge
    always_ff @(posedge clock)
    begin
        if (accept)
        begin
            op_entry.op   <= instr_op;
            op_entry.dest <= instr_rd;
            op_entry.a    <= regs[instr_rs1];
            op_entry.b    <= regs[instr_rs2];
            op_entry.link <= regs[core_pkg::link_reg];
            op_entry.imm  <= instr_imm;
            op_entry.high <= instr_high;
        end
    end

endmodule

// File: source/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo
#(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
)
(
    input  logic        clock,
    input  logic        arst_n,
    input  logic        push,
    input  payload_t    push_data,
    input  logic        pop,
    output payload_t    head,
    output logic        empty,
    output logic        full
);

    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_width = $clog2(depth + 1);

    payload_t               mem [depth];
    logic [ptr_width-1:0]   rd_ptr;
    logic [ptr_width-1:0]   wr_ptr;
    logic [cnt_width-1:0]   count;
    logic                   do_push;
    logic                   do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign empty = (count == '0);
    assign full  = (count == cnt_width'(depth));
    assign head  = mem[rd_ptr];  // Oldest entry, no read latency

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither leave occupancy as is
            endcase
        end
    end

    always_ff @(posedge clock)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

// File: verification/alu_core_props.sv
`timescale 1ns/100ps

module alu_core_props
(
    input logic clock,
    input logic arst_n,
    input logic push,
    input logic full,
    input logic pop,
    input logic empty,
    input logic ready,
    input logic src_busy
);

    // ******************************
    // Queue discipline
    // ******************************
    no_push_when_full: assert property (@(posedge clock) disable iff (!arst_n) push |-> !full)
        else $error("push while the queue is full");

    no_pop_when_empty: assert property (@(posedge clock) disable iff (!arst_n) pop |-> !empty)
        else $error("pop while the queue is empty");

    // Scoreboard holds off any reader of a register awaiting writeback
    ready_low_on_hazard: assert property (@(posedge clock) disable iff (!arst_n)
                                          src_busy |-> !ready)
        else $error("instr_ready high while a source register is being written back");

endmodule

bind sync_fifo alu_core_props u_fifo_props
(
    .clock    (clock),
    .arst_n   (arst_n),
    .push     (push),
    .full     (full),
    .pop      (pop),
    .empty    (empty),
    .ready    (1'b0),
    .src_busy (1'b0)
);

bind operand_issue alu_core_props u_issue_props
(
    .clock    (clock),
    .arst_n   (arst_n),
    .push     (op_push),
    .full     (op_full),
    .pop      (1'b0),
    .empty    (1'b0),
    .ready    (instr_ready),
    .src_busy (wb_en & ((wb_addr == instr_rs1) | (wb_addr == instr_rs2)))
);

// File: verification/alu_core_stim.txt
# op rd rs1 rs2 imm high, then the expected value flag taken target, all hex
# opcodes: 0 add 1 sub 2 shl 3 shr 4 mov 5 ldh 6 br 7 brf 8 ceq 9 clt a cgt 10 mul 11 div
05 1 0 0 12345678 1 1234567800000000 0 0 0
05 1 1 0 9abcdef0 0 123456789abcdef0 0 0 0
05 2 0 0 00000010 0 0000000000000010 0 0 0
05 3 0 0 ffffffff 1 ffffffff00000000 0 0 0
00 4 1 2 00000000 0 123456789abcdf00 0 0 0
01 5 2 1 00000000 0 edcba98765432120 0 0 0
04 6 4 0 00000000 0 123456789abcdf00 0 0 0
00 7 6 3 00000000 0 123456779abcdf00 0 0 0
05 9 0 0 00000004 0 0000000000000004 0 0 0
02 a 1 9 00000000 0 23456789abcdef0f 0 0 0
03 b 1 9 00000000 0 f123456789abcdef 0 0 0
02 c 1 0 00000000 0 123456789abcdef0 0 0 0
05 d 0 0 0000003f 0 000000000000003f 0 0 0
03 e 2 d 00000000 0 fffffffffffffffe 0 0 0
02 f 1 d 00000000 0 7fffffffffffffff 0 0 0
05 d 0 0 00000040 0 0000000000000040 0 0 0
03 a 1 d 00000000 0 ffffffffffffffff 0 0 0
02 b 2 3 00000000 0 ffffffffffffffff 0 0 0
05 c 7 0 cafef00d 1 cafef00d9abcdf00 0 0 0
05 c c 0 0badc0de 0 cafef00d0badc0de 0 0 0
05 8 0 0 00001000 0 0000000000001000 0 0 0
08 0 4 6 00000000 0 0000000000000000 1 0 0
07 0 1 0 00000000 0 123456789abcdef0 1 1 1000
09 0 1 2 00000000 0 0000000000000000 0 0 0
07 0 2 0 00000000 0 0000000000000010 0 0 1000
0a 0 3 1 00000000 0 0000000000000000 1 0 0
06 0 0 0 00000000 0 0000000000000000 1 1 1000
09 0 2 3 00000000 0 0000000000000000 1 0 0
08 0 1 c 00000000 0 0000000000000000 0 0 0
06 0 5 0 00000000 0 edcba98765432120 0 1 1000
10 4 2 1 00000000 0 23456789abcdef00 0 0 0
10 6 7 9 00000000 0 48d159de6af37c00 0 0 0
11 a 1 9 00000000 0 048d159e26af37bc 0 0 0
11 b 1 0 00000000 0 ffffffffffffffff 0 0 0
11 c 3 2 00000000 0 0ffffffff0000000 0 0 0

// File: verification/alu_core_tb.sv
`timescale 1ns/100ps

module alu_core_tb;

    // One instruction and the result record it should produce
    typedef struct packed
    {
        logic [4:0]                     op;
        core_pkg::reg_addr_t            rd;
        core_pkg::reg_addr_t            rs1;
        core_pkg::reg_addr_t            rs2;
        logic [alu_pkg::imm_width-1:0]  imm;
        logic                           high;
        alu_pkg::data_t                 value;
        logic                           flag;
        logic                           taken;
        alu_pkg::data_t                 target;
    } stim_t;

    logic                           clock;
    logic                           arst_n;
    logic                           instr_valid;
    alu_pkg::opcode_t               instr_op;
    core_pkg::reg_addr_t            instr_rd;
    core_pkg::reg_addr_t            instr_rs1;
    core_pkg::reg_addr_t            instr_rs2;
    logic [alu_pkg::imm_width-1:0]  instr_imm;
    logic                           instr_high;
    logic                           instr_ready;
    logic                           res_pop;
    logic                           res_valid;
    core_pkg::result_t              res_data;

    stim_t  stim_q [$];
    logic   loaded;
    int     seed;

    alu_core_top u_alu_core_top
    (
        .clock       (clock),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr_op    (instr_op),
        .instr_rd    (instr_rd),
        .instr_rs1   (instr_rs1),
        .instr_rs2   (instr_rs2),
        .instr_imm   (instr_imm),
        .instr_high  (instr_high),
        .instr_ready (instr_ready),
        .res_pop     (res_pop),
        .res_valid   (res_valid),
        .res_data    (res_data)
    );

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // ******************************
    // Failure reporting and checks
    // ******************************
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_opcode(input alu_pkg::opcode_t got, input alu_pkg::opcode_t exp,
                                input int idx);
        if (got !== exp)
            abort_run($sformatf("[FAIL] res_data.op got %h expected %h (record %0d)",
                                got, exp, idx));
    endtask

    task automatic check_dest(input core_pkg::reg_addr_t got, input core_pkg::reg_addr_t exp,
                              input int idx);
        if (got !== exp)
            abort_run($sformatf("[FAIL] res_data.dest got %h expected %h (record %0d)",
                                got, exp, idx));
    endtask

    task automatic check_value(input alu_pkg::data_t got, input alu_pkg::data_t exp,
                               input int idx);
        if (got !== exp)
            abort_run($sformatf("[FAIL] res_data.value got %h expected %h (record %0d)",
                                got, exp, idx));
    endtask

    task automatic check_flag(input logic got, input logic exp, input int idx);
        if (got !== exp)
            abort_run($sformatf("[FAIL] res_data.flag got %h expected %h (record %0d)",
                                got, exp, idx));
    endtask

    task automatic check_branch(input logic got, input logic exp, input int idx);
        if (got !== exp)
            abort_run($sformatf("[FAIL] res_data.taken got %h expected %h (record %0d)",
                                got, exp, idx));
    endtask

    task automatic check_target(input alu_pkg::data_t got, input alu_pkg::data_t exp,
                                input int idx);
        if (got !== exp)
            abort_run($sformatf("[FAIL] res_data.target got %h expected %h (record %0d)",
                                got, exp, idx));
    endtask

    task automatic check_record(input int idx);
        check_opcode(res_data.op, alu_pkg::opcode_t'(stim_q[idx].op), idx);
        check_dest(res_data.dest, stim_q[idx].rd, idx);
        check_value(res_data.value, stim_q[idx].value, idx);
        check_flag(res_data.flag, stim_q[idx].flag, idx);
        check_branch(res_data.taken, stim_q[idx].taken, idx);
        check_target(res_data.target, stim_q[idx].target, idx);
    endtask

    // ******************************
    // Stimulus file
    // ******************************
    task automatic load_stim();
        int                             fd;
        int                             n;
        string                          line;
        logic [4:0]                     f_op;
        core_pkg::reg_addr_t            f_rd;
        core_pkg::reg_addr_t            f_rs1;
        core_pkg::reg_addr_t            f_rs2;
        logic [alu_pkg::imm_width-1:0]  f_imm;
        logic                           f_high;
        alu_pkg::data_t                 f_value;
        logic                           f_flag;
        logic                           f_taken;
        alu_pkg::data_t                 f_target;
        fd = $fopen("verification/alu_core_stim.txt", "r");
        if (fd == 0)
            abort_run("could not open the stimulus file verification/alu_core_stim.txt");
        while ($fgets(line, fd) > 0)
        begin
            if (line.len() > 1 && line.getc(0) != "#")  // Blank and comment lines skipped
            begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_op, f_rd, f_rs1, f_rs2,
                            f_imm, f_high, f_value, f_flag, f_taken, f_target);
                if (n != 10)
                    abort_run($sformatf("stimulus line has %0d fields instead of 10", n));
                else
                    stim_q.push_back({f_op, f_rd, f_rs1, f_rs2, f_imm, f_high,
                                      f_value, f_flag, f_taken, f_target});
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_instructions();
        stim_t s;
        foreach (stim_q[i])
        begin
            s = stim_q[i];
            @(negedge clock);
            instr_valid = 1'b1;
            instr_op    = alu_pkg::opcode_t'(s.op);
            instr_rd    = s.rd;
            instr_rs1   = s.rs1;
            instr_rs2   = s.rs2;
            instr_imm   = s.imm;
            instr_high  = s.high;
            #1;
            while (!instr_ready)  // Queue full or a register still pending
            begin
                @(negedge clock);
                #1;
            end
            @(posedge clock);
        end
        @(negedge clock);
        instr_valid = 1'b0;
    endtask

    task automatic drain_results();
        int received;
        received = 0;
        while (received < stim_q.size())
        begin
            @(negedge clock);
            if (res_valid && (($random(seed) & 7) < 3))  // Sparse pops let the queues fill
            begin
                res_pop = 1'b1;
                check_record(received);
                received++;
            end
            else
            begin
                res_pop = 1'b0;
            end
        end
        @(negedge clock);
        res_pop = 1'b0;
    endtask

    // ******************************
    // Main sequence and watchdog
    // ******************************
    initial
    begin
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr_op    = alu_pkg::op_add;
        instr_rd    = '0;
        instr_rs1   = '0;
        instr_rs2   = '0;
        instr_imm   = '0;
        instr_high  = 1'b0;
        res_pop     = 1'b0;
        seed        = 31156;
        loaded      = 1'b0;
        load_stim();
        loaded = 1'b1;
        repeat (10) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        fork
            drive_instructions();
            drain_results();
        join
        repeat (5) @(negedge clock);
        if (res_valid)
            abort_run("result queue still holds a record after the last expected one");
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

    initial
    begin
        wait (loaded);
        repeat (stim_q.size() * 40 + 200) @(posedge clock);
        abort_run("watchdog expired before all results arrived");
    end

endmodule
